// File: src/div_pkg.sv
/*
 * integer divide unit definitions
 * widths, register write and divide request payloads, and the
 * divider state encoding shared by the divider, arbiter and register file
 */

`default_nettype none

package div_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int unsigned data_width    = 32;  // operand and register width
    localparam int unsigned num_regs      = 32;  // architectural registers
    localparam int unsigned reg_sel_width = $clog2(num_regs);
    localparam int unsigned pos_width     = $clog2(data_width);  // quotient bit index

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one register file write, sel of zero targets the zero register
    typedef struct packed {
        logic [reg_sel_width-1:0] sel;
        logic [data_width-1:0]    data;
    } rf_wr_t;

    // one divide as issued by the client
    typedef struct packed {
        logic [data_width-1:0]    a;         // dividend
        logic [data_width-1:0]    b;         // divisor
        logic [reg_sel_width-1:0] quot_sel;  // 0 skips the quotient write
        logic [reg_sel_width-1:0] mod_sel;   // 0 skips the remainder write
    } div_req_t;

    // divider sequencing
    typedef enum logic [1:0] {
        IDLE,
        CALC,
        WRITING_QUOTIENT,
        WRITING_MODULUS
    } div_state_e;

endpackage

`default_nettype wire

// File: src/int_div_regfile.sv
/*
 * sequential restoring integer divider
 * one quotient bit per clock from the top bit down, then writes the
 * quotient and the remainder to the register file over req/ack,
 * skipping any write whose selector is zero
 */

`timescale 1ns/1ps
`default_nettype none

module int_div_regfile
    import div_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  logic     req,        // one-cycle issue strobe
    input  div_req_t op,
    output logic     busy,

    output logic     rf_wr_req,  // held until acked
    output rf_wr_t   rf_wr,
    input  logic     rf_wr_ack
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    div_state_e               state;
    div_state_e               next_state;
    logic [pos_width-1:0]     pos;        // bit being resolved in CALC

    logic [data_width-1:0]    divisor;
    logic [reg_sel_width-1:0] quot_sel;
    logic [reg_sel_width-1:0] mod_sel;
    logic [data_width-1:0]    remainder;  // dividend still left over
    logic [data_width-1:0]    quotient;

    logic [2*data_width-1:0]  shifted_b;
    logic                     fits;

    // trial compare at double width so the shift never drops bits
    always_comb begin
        shifted_b = {{data_width{1'b0}}, divisor} << pos;
        fits      = shifted_b <= {{data_width{1'b0}}, remainder};  // equal counts as a fit
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (req) next_state = CALC;
            end
            CALC: begin
                // last bit, pick the first write that is not skipped
                if (pos == '0) begin
                    if (quot_sel != '0)
                        next_state = WRITING_QUOTIENT;
                    else if (mod_sel != '0)
                        next_state = WRITING_MODULUS;
                    else
                        next_state = IDLE;
                end
            end
            WRITING_QUOTIENT: begin
                if (rf_wr_ack) next_state = (mod_sel != '0) ? WRITING_MODULUS : IDLE;
            end
            WRITING_MODULUS: begin
                if (rf_wr_ack) next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            pos   <= '0;
        end else begin
            state <= next_state;
            if (state == IDLE && req)
                pos <= pos_width'(data_width - 1);  // start at the top bit
            else if (state == CALC && pos != '0)
                pos <= pos - 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            divisor   <= op.b;
            quot_sel  <= op.quot_sel;
            mod_sel   <= op.mod_sel;
            remainder <= op.a;
            quotient  <= '0;
        end else if (state == CALC && fits) begin
            // a zero divisor always fits, giving all ones and the dividend back
            remainder     <= remainder - shifted_b[data_width-1:0];
            quotient[pos] <= 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign busy      = (state != IDLE);
    assign rf_wr_req = (state == WRITING_QUOTIENT) || (state == WRITING_MODULUS);

    always_comb begin
        if (state == WRITING_QUOTIENT) begin
            rf_wr.sel  = quot_sel;
            rf_wr.data = quotient;
        end else begin
            rf_wr.sel  = mod_sel;
            rf_wr.data = remainder;
        end
    end

    // the client has no back-pressure, so a second issue would be lost
    a_no_req_while_busy: assert property (
        @(posedge clk) disable iff (rst) busy |-> !req
    ) else $error("divide issued while busy");

    // an unacked write must be presented unchanged on the next cycle
    a_wr_held: assert property (
        @(posedge clk) disable iff (rst)
        rf_wr_req && !rf_wr_ack |=> rf_wr_req && $stable(rf_wr)
    ) else $error("divider write changed before ack");

endmodule

`default_nettype wire

// File: src/wb_arbiter.sv
/*
 * register file write port arbiter
 * fixed priority, the core write-back always wins and the divider
 * is acked in the same cycle only when the port is free
 */

`timescale 1ns/1ps
`default_nettype none

module wb_arbiter
    import div_pkg::*;
(
    // core write-back, no back-pressure
    input  logic   core_wr,
    input  rf_wr_t core_wr_data,

    // divider write, req/ack
    input  logic   div_wr_req,
    input  rf_wr_t div_wr,
    output logic   div_wr_ack,

    // shared write port
    output logic   wr_en,
    output rf_wr_t wr
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // grant
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        wr_en      = 1'b0;
        wr         = div_wr;
        div_wr_ack = 1'b0;

        if (core_wr) begin
            wr_en = 1'b1;
            wr    = core_wr_data;  // divider keeps waiting
        end else if (div_wr_req) begin
            wr_en      = 1'b1;
            wr         = div_wr;
            div_wr_ack = 1'b1;     // write lands on this edge
        end
    end

endmodule

`default_nettype wire

// File: src/reg_file.sv
/*
 * architectural register file
 * one synchronous write port and one combinational read port,
 * register zero is hard-wired to zero
 */

`timescale 1ns/1ps
`default_nettype none

module reg_file
    import div_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     wr_en,
    input  rf_wr_t                   wr,

    input  logic [reg_sel_width-1:0] rd_sel,
    output logic [data_width-1:0]    rd_data
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // no storage behind register zero
    logic [data_width-1:0] regs [1:num_regs-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr.sel != '0) begin
            regs[wr.sel] <= wr.data;  // writes to zero are dropped
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (rd_sel == '0)
            rd_data = '0;
        else
            rd_data = regs[rd_sel];
    end

endmodule

`default_nettype wire

// File: src/div_subsystem.sv
/*
 * integer divide subsystem
 * divider, write port arbiter and register file, with the core
 * write-back sharing the single register file write port
 */

`timescale 1ns/1ps
`default_nettype none

module div_subsystem
    import div_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    // divide issue
    input  logic                     div_req,
    input  div_req_t                 div_op,
    output logic                     busy,

    // core write-back
    input  logic                     core_wr,
    input  rf_wr_t                   core_wr_data,

    // observation read port
    input  logic [reg_sel_width-1:0] rd_sel,
    output logic [data_width-1:0]    rd_data
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // internal wires
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic   div_wr_req;
    rf_wr_t div_wr;
    logic   div_wr_ack;
    logic   wr_en;
    rf_wr_t wr;

    int_div_regfile u_div (
        .clk       (clk),
        .rst       (rst),
        .req       (div_req),
        .op        (div_op),
        .busy      (busy),
        .rf_wr_req (div_wr_req),
        .rf_wr     (div_wr),
        .rf_wr_ack (div_wr_ack)
    );

    wb_arbiter u_arb (
        .core_wr      (core_wr),
        .core_wr_data (core_wr_data),
        .div_wr_req   (div_wr_req),
        .div_wr       (div_wr),
        .div_wr_ack   (div_wr_ack),
        .wr_en        (wr_en),
        .wr           (wr)
    );

    reg_file u_rf (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr      (wr),
        .rd_sel  (rd_sel),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// File: tests/div_checker.sv
/*
 * divide subsystem checker
 * keeps a shadow copy of the register file from the observed core writes
 * and divide issues, checks busy timing and compares read-back data
 */

`timescale 1ns/1ps
`default_nettype none

module div_checker
    import div_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     div_req,
    input  div_req_t                 div_op,
    input  logic                     busy,
    input  logic                     core_wr,
    input  rf_wr_t                   core_wr_data,
    input  logic [reg_sel_width-1:0] rd_sel,
    input  logic [data_width-1:0]    rd_data,
    input  logic                     check_en,  // a read-back sweep is running
    input  logic [2:0]               test_id,
    output int                       checks,
    output int                       errors
);

    logic [data_width-1:0]   shadow [num_regs];
    logic [data_width-1:0]   expected;
    logic [2*data_width-1:0] result;
    logic                    rise_pending;  // busy must be high at the next edge
    logic                    tracking;      // counting the busy window
    int                      busy_cycles;
    int                      min_cycles;    // calc plus one per nonzero selector
    int                      core_stalls;   // core writes seen while busy

    // integer divide rule, quotient in the upper half
    function automatic logic [2*data_width-1:0] ref_divide(input logic [data_width-1:0] a,
                                                           input logic [data_width-1:0] b);
        if (b == '0)
            return {{data_width{1'b1}}, a};  // all ones, dividend kept
        return {a / b, a % b};
    endfunction

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "reset";
            3'd1:    return "random";
            3'd2:    return "sel_zero";
            3'd3:    return "div_zero_exact";
            3'd4:    return "contention";
            default: return "zero_reg";
        endcase
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                shadow[i] = '0;
            end
            checks       = 0;
            errors       = 0;
            rise_pending = 1'b0;
            tracking     = 1'b0;
            busy_cycles  = 0;
            min_cycles   = 0;
            core_stalls  = 0;
        end else begin
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // busy timing
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            if (rise_pending) begin
                checks++;
                rise_pending = 1'b0;
                if (!busy) begin
                    errors++;
                    $display("busy did not rise in the cycle after issue in test %s",
                             test_name(test_id));
                end
            end
            if (tracking) begin
                if (busy) begin
                    busy_cycles++;
                    if (core_wr)
                        core_stalls++;  // may hold off one divider write
                end else begin
                    checks++;
                    tracking = 1'b0;
                    if (busy_cycles < min_cycles || busy_cycles > min_cycles + core_stalls) begin
                        errors++;
                        $display("Error: test %s, busy cycles, expected %0d to %0d, actual %0d",
                                 test_name(test_id), min_cycles, min_cycles + core_stalls,
                                 busy_cycles);
                    end
                end
            end

            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // read-back compare
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            if (check_en) begin
                checks++;
                expected = (rd_sel == '0) ? '0 : shadow[rd_sel];
                if (rd_data !== expected) begin
                    errors++;
                    $display("Error: test %s, register %0d, expected %08h, actual %08h",
                             test_name(test_id), rd_sel, expected, rd_data);
                end
                if (busy) begin
                    errors++;
                    $display("busy was high while reading back register %0d", rd_sel);
                end
            end

            // shadow updates, divide results land after any core write
            if (core_wr && core_wr_data.sel != '0)
                shadow[core_wr_data.sel] = core_wr_data.data;
            if (div_req) begin
                result = ref_divide(div_op.a, div_op.b);
                if (div_op.quot_sel != '0)
                    shadow[div_op.quot_sel] = result[2*data_width-1:data_width];
                if (div_op.mod_sel != '0)
                    shadow[div_op.mod_sel] = result[data_width-1:0];
                rise_pending = 1'b1;
                tracking     = 1'b1;
                busy_cycles  = 0;
                core_stalls  = 0;
                min_cycles   = data_width + int'(div_op.quot_sel != '0)
                                          + int'(div_op.mod_sel != '0);
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_div_subsystem.sv
/*
 * divide subsystem testbench
 * LFSR driven divides with and without core write contention,
 * register sweeps after each divide, watchdog and closing report
 */

`timescale 1ns/1ps
`default_nettype none

module tb_div_subsystem
    import div_pkg::*;
();

    localparam int          num_random  = 40;
    localparam int          num_contend = 20;
    localparam int          total_ops   = num_random + num_contend + 7;
    localparam int          busy_limit  = data_width + 64;
    localparam longint      timeout_ns  = total_ops * (data_width + 8 + num_regs) * 10 * 2;
    localparam logic [31:0] lfsr_seed   = 32'h4af664f9;

    logic                     clk;
    logic                     rst;
    logic                     div_req;
    div_req_t                 div_op;
    logic                     busy;
    logic                     core_wr;
    rf_wr_t                   core_wr_data;
    logic [reg_sel_width-1:0] rd_sel;
    logic [data_width-1:0]    rd_data;
    logic                     check_en;
    logic [2:0]               test_id;
    int                       checks;
    int                       chk_errors;
    int                       tb_errors;
    logic [31:0]              lfsr;
    div_req_t                 op;

    div_subsystem i_dut (
        .clk          (clk),
        .rst          (rst),
        .div_req      (div_req),
        .div_op       (div_op),
        .busy         (busy),
        .core_wr      (core_wr),
        .core_wr_data (core_wr_data),
        .rd_sel       (rd_sel),
        .rd_data      (rd_data)
    );

    div_checker i_checker (
        .clk          (clk),
        .rst          (rst),
        .div_req      (div_req),
        .div_op       (div_op),
        .busy         (busy),
        .core_wr      (core_wr),
        .core_wr_data (core_wr_data),
        .rd_sel       (rd_sel),
        .rd_data      (rd_data),
        .check_en     (check_en),
        .test_id      (test_id),
        .checks       (checks),
        .errors       (chk_errors)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random source
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // distinct nonzero selectors, divisor scaled down now and then
    function automatic div_req_t random_op();
        div_req_t o;
        o.a = rand_bits(data_width);
        o.b = rand_bits(data_width) >> rand_bits(pos_width);
        do o.quot_sel = reg_sel_width'(rand_bits(reg_sel_width));
        while (o.quot_sel == '0);
        do o.mod_sel = reg_sel_width'(rand_bits(reg_sel_width));
        while (o.mod_sel == '0 || o.mod_sel == o.quot_sel);
        return o;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic read_back();
        for (int i = 0; i < num_regs; i++) begin
            @(negedge clk);
            rd_sel   = reg_sel_width'(i);
            check_en = 1'b1;
        end
        @(negedge clk);
        check_en = 1'b0;
    endtask

    task automatic core_write(input logic [reg_sel_width-1:0] sel, input logic [31:0] data);
        @(negedge clk);
        core_wr           = 1'b1;
        core_wr_data.sel  = sel;
        core_wr_data.data = data;
        @(negedge clk);
        core_wr = 1'b0;
    endtask

    // issue, wait for busy to fall, optionally with core writes to other registers
    task automatic run_divide(input div_req_t o, input bit contend);
        int                       waited;
        logic [reg_sel_width-1:0] sel;
        @(negedge clk);
        div_req = 1'b1;
        div_op  = o;
        @(negedge clk);
        div_req = 1'b0;
        waited  = 0;
        while (busy && waited < busy_limit) begin
            core_wr = 1'b0;
            if (contend && rand_bits(1) == 1) begin
                sel = reg_sel_width'(rand_bits(reg_sel_width));
                if (sel != o.quot_sel && sel != o.mod_sel) begin
                    core_wr           = 1'b1;  // sel of zero is allowed here
                    core_wr_data.sel  = sel;
                    core_wr_data.data = rand_bits(data_width);
                end
            end
            waited++;
            @(negedge clk);
        end
        core_wr = 1'b0;
        if (busy) begin
            tb_errors++;
            $display("divider still busy %0d cycles after issue", waited);
        end
        read_back();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        rst          = 1'b1;
        div_req      = 1'b0;
        div_op       = '0;
        core_wr      = 1'b0;
        core_wr_data = '0;
        rd_sel       = '0;
        check_en     = 1'b0;
        test_id      = 3'd0;
        tb_errors    = 0;
        lfsr         = lfsr_seed;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        read_back();  // everything zero after reset

        test_id = 3'd1;
        repeat (num_random) run_divide(random_op(), 1'b0);

        test_id = 3'd2;
        op = random_op();
        op.quot_sel = '0;
        run_divide(op, 1'b0);
        op = random_op();
        op.mod_sel = '0;
        run_divide(op, 1'b0);
        op = random_op();
        op.quot_sel = '0;
        op.mod_sel  = '0;
        run_divide(op, 1'b0);

        test_id = 3'd3;
        op = random_op();
        op.b = '0;
        run_divide(op, 1'b0);
        op = random_op();
        op.b = data_width'(rand_bits(16)) | 1;
        op.a = op.b * rand_bits(16);  // exact multiple
        run_divide(op, 1'b0);
        op = random_op();
        op.a = op.b;
        run_divide(op, 1'b0);

        test_id = 3'd4;
        repeat (num_contend) run_divide(random_op(), 1'b1);

        test_id = 3'd5;
        core_write('0, rand_bits(data_width));
        run_divide(random_op(), 1'b1);

        $display("checks %0d, checker errors %0d, sequencing errors %0d",
                 checks, chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns before all divides finished", timeout_ns);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
src/div_pkg.sv
src/int_div_regfile.sv
src/wb_arbiter.sv
src/reg_file.sv
src/div_subsystem.sv
tests/div_checker.sv
tests/tb_div_subsystem.sv

// File: Bender.yml
package:
  name: div_subsystem

sources:
  - src/div_pkg.sv
  - src/int_div_regfile.sv
  - src/wb_arbiter.sv
  - src/reg_file.sv
  - src/div_subsystem.sv
  - target: test
    files:
      - tests/div_checker.sv
      - tests/tb_div_subsystem.sv
